// File: hdl/dz_pkg.sv
`default_nettype none

package dz_pkg;

    // scan and digit periods, short for simulation
    localparam int ROW_TICKS   = 4;
    localparam int DIGIT_TICKS = 64;    // two full frames per digit
    localparam int MAX_DIGIT   = 5;

    localparam int ROW_CNT_W   = $clog2(ROW_TICKS);
    localparam int DIGIT_CNT_W = $clog2(DIGIT_TICKS);

    typedef logic [2:0] digit_t;    // 0 is blank

    typedef enum logic [1:0] {
        hue_off,
        hue_red,
        hue_green,
        hue_yellow    // red and green together
    } hue_t;

    typedef enum logic {
        seq_idle,
        seq_count
    } seq_state_t;

    // glyph_rows[digit][row], row 0 is left dark
    localparam logic [7:0] glyph_rows [0:5][0:7] = '{
        '{
            8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
            8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000
        },
        '{
            8'b0000_0000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0011_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0111_1110
        },
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0000_1100,
            8'b0011_0000,
            8'b0110_0000,
            8'b0111_1110
        },
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0001_1100,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100
        },
        '{
            8'b0000_0000,
            8'b0000_1100,
            8'b0001_1100,
            8'b0010_1100,
            8'b0100_1100,
            8'b0111_1110,
            8'b0000_1100,
            8'b0000_1100
        },
        '{
            8'b0000_0000,
            8'b0111_1110,
            8'b0110_0000,
            8'b0111_1100,
            8'b0000_0110,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100
        }
    };

    // colour goes red -> yellow -> green as the count falls
    localparam hue_t digit_hue [0:5] = '{
        hue_off,
        hue_green,
        hue_yellow,
        hue_yellow,
        hue_red,
        hue_red
    };

endpackage

`default_nettype wire

// File: hdl/scan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

    logic [2:0] row_idx;
    logic [7:0] row_sel;        // one-hot copy of row_idx
    logic       frame_start;    // first cycle of row 0
    logic       blank;          // first cycle of each row period

    modport scanner (
        output row_idx, row_sel, frame_start, blank
    );

    modport renderer (
        input row_idx, row_sel, frame_start, blank
    );

endinterface

`default_nettype wire

// File: hdl/row_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module row_scanner
    import dz_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    scan_if.scanner  scan
);

    logic [ROW_CNT_W-1:0] tick;
    logic [2:0]           row_q;
    logic                 row_end;

    assign row_end = (tick == ROW_CNT_W'(ROW_TICKS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick  <= '0;
            row_q <= 3'd0;
        end
        else if (row_end)
        begin
            tick  <= '0;
            row_q <= row_q + 3'd1;    // 7 wraps to 0
        end
        else
        begin
            tick <= tick + 1'b1;
        end
    end

    assign scan.row_idx = row_q;
    assign scan.row_sel = 8'b0000_0001 << row_q;

    // dark cycle at every row change, keeps the previous row from ghosting
    assign scan.blank       = (tick == '0);
    assign scan.frame_start = (tick == '0) && (row_q == 3'd0);

endmodule

`default_nettype wire

// File: hdl/countdown_seq.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_seq
    import dz_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  digit_t load_num,
    output digit_t digit,
    output logic   done
);

    seq_state_t             state;
    logic [DIGIT_CNT_W-1:0] tick;
    logic                   load_ok;
    logic                   expire;

    // only 1..MAX_DIGIT starts a count, anything else is dropped
    assign load_ok = start && (load_num != '0) && (load_num <= digit_t'(MAX_DIGIT));

    assign expire = (tick == DIGIT_CNT_W'(DIGIT_TICKS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= seq_idle;
            digit <= '0;
            tick  <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (load_ok)
            begin
                // also a restart when already counting
                state <= seq_count;
                digit <= load_num;
                tick  <= '0;
            end
            else
            begin
                case (state)
                    seq_idle:
                    begin
                        tick <= '0;
                    end
                    seq_count:
                    begin
                        if (expire)
                        begin
                            tick  <= '0;
                            digit <= digit - 1'b1;
                            if (digit == digit_t'(1))
                            begin
                                state <= seq_idle;
                                done  <= 1'b1;    // one cycle, as the display blanks
                            end
                        end
                        else
                        begin
                            tick <= tick + 1'b1;
                        end
                    end
                    default:
                    begin
                        state <= seq_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dz_show.sv
`timescale 1ns/1ps
`default_nettype none

module dz_show
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    scan_if.renderer   scan,
    input  digit_t     digit,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic [7:0] glyph;
    hue_t       hue;
    logic       red_on;
    logic       green_on;

    always_comb
    begin
        if (digit <= digit_t'(MAX_DIGIT))
        begin
            glyph = glyph_rows[digit][scan.row_idx];
            hue   = digit_hue[digit];
        end
        else
        begin
            glyph = 8'h00;
            hue   = hue_off;
        end
    end

    always_comb
    begin
        case (hue)
            hue_red:    {red_on, green_on} = 2'b10;
            hue_green:  {red_on, green_on} = 2'b01;
            hue_yellow: {red_on, green_on} = 2'b11;
            default:    {red_on, green_on} = 2'b00;
        endcase
    end

    // row and columns go out on the same edge so they stay aligned
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row   <= 8'h00;
            colr  <= 8'h00;
            colg  <= 8'h00;
        end
        else
        begin
            if (scan.blank)
            begin
                row  <= 8'h00;
                colr <= 8'h00;
                colg <= 8'h00;
            end
            else
            begin
                row  <= scan.row_sel;
                colr <= red_on ? glyph : 8'h00;
                colg <= green_on ? glyph : 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dz_countdown_top.sv
`timescale 1ns/1ps
`default_nettype none

module dz_countdown_top
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  digit_t     load_num,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg,
    output logic       done
);

    scan_if scan_bus ();

    digit_t digit;    // current count, 0 when idle

    row_scanner row_scanner_inst (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_bus.scanner)
    );

    countdown_seq countdown_seq_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .load_num (load_num),
        .digit    (digit),
        .done     (done)
    );

    // renderer adds the single register stage ahead of the pins
    dz_show dz_show_inst (
        .clk   (clk),
        .rst   (rst),
        .scan  (scan_bus.renderer),
        .digit (digit),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

`default_nettype wire

// File: dv/dz_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dz_checker
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  digit_t     load_num,
    input  logic [7:0] row,
    input  logic [7:0] colr,
    input  logic [7:0] colg,
    input  logic       done,
    output int         errors,
    output int         checks
);

    int         err_cnt = 0;
    int         chk_cnt = 0;

    // reference model of scan position and count
    int         m_tick = 0;
    logic [2:0] m_row = 3'd0;
    digit_t     m_digit = '0;
    int         m_cnt = 0;
    int         cyc = 0;
    int         last_start = 0;
    int         last_load = 0;

    // pin values expected after the latest rising edge
    logic [7:0] exp_row = 8'h00;
    logic [7:0] exp_colr = 8'h00;
    logic [7:0] exp_colg = 8'h00;
    logic       exp_done = 1'b0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want);
        chk_cnt++;
        if (got !== want)
        begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
            err_cnt++;
        end
    endtask

    always @(posedge clk or posedge rst)
    begin
        logic [7:0] glyph;
        logic       red_on;
        logic       green_on;
        if (rst)
        begin
            m_tick   = 0;
            m_row    = 3'd0;
            m_digit  = '0;
            m_cnt    = 0;
            cyc      = 0;
            exp_row  = 8'h00;
            exp_colr = 8'h00;
            exp_colg = 8'h00;
            exp_done = 1'b0;
        end
        else
        begin
            cyc = cyc + 1;
            // register stage sees the state from before this edge
            glyph    = glyph_rows[m_digit][m_row];
            red_on   = (m_digit >= digit_t'(2));    // 5 4 red, 3 2 yellow
            green_on = (m_digit >= digit_t'(1)) && (m_digit <= digit_t'(3));
            if (m_tick == 0)
            begin
                exp_row  = 8'h00;
                exp_colr = 8'h00;
                exp_colg = 8'h00;
            end
            else
            begin
                exp_row  = 8'b0000_0001 << m_row;
                exp_colr = red_on ? glyph : 8'h00;
                exp_colg = green_on ? glyph : 8'h00;
            end
            exp_done = 1'b0;
            if (start && (load_num >= digit_t'(1)) && (load_num <= digit_t'(MAX_DIGIT)))
            begin
                m_digit    = load_num;
                m_cnt      = 0;
                last_start = cyc;
                last_load  = int'(load_num);
            end
            else if (m_digit != '0)
            begin
                if (m_cnt == DIGIT_TICKS - 1)
                begin
                    m_cnt    = 0;
                    m_digit  = m_digit - digit_t'(1);
                    exp_done = (m_digit == '0);
                end
                else
                    m_cnt = m_cnt + 1;
            end
            if (m_tick == ROW_TICKS - 1)
            begin
                m_tick = 0;
                m_row  = m_row + 3'd1;
            end
            else
                m_tick = m_tick + 1;
        end
    end

    // outputs settle after the rising edge, look at them half a cycle later
    always @(negedge clk)
    begin
        compare("row", row, exp_row);
        compare("colr", colr, exp_colr);
        compare("colg", colg, exp_colg);
        compare("done", {7'b0, done}, {7'b0, exp_done});
        if (!$onehot0(row))
        begin
            $display("at %0t row %b selects more than one line", $time, row);
            err_cnt++;
        end
        if (!rst && done)
        begin
            chk_cnt++;
            if (cyc - last_start != last_load * DIGIT_TICKS)
            begin
                $display("Fail at %0t: done delay got %0d expected %0d", $time,
                         cyc - last_start, last_load * DIGIT_TICKS);
                err_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_dz_countdown.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dz_countdown
    import dz_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       start;
    digit_t     load_num;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;
    logic       done;
    int         errors;
    int         checks;

    // load value (-1 picks a random valid digit), idle cycles after, done expected
    localparam int num_tests = 8;
    localparam int load_tab [0:7] = '{5, 0, 6, 7, 3, 4, -1, 1};
    localparam int hold_tab [0:7] = '{20, 80, 80, 80, 20, 100, 20, 40};
    localparam bit done_tab [0:7] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

    always #2 clk = ~clk;

    dz_countdown_top dz_countdown_top_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .load_num (load_num),
        .row      (row),
        .colr     (colr),
        .colg     (colg),
        .done     (done)
    );

    dz_checker dz_checker_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .load_num (load_num),
        .row      (row),
        .colr     (colr),
        .colg     (colg),
        .done     (done),
        .errors   (errors),
        .checks   (checks)
    );

    task automatic pulse_start(input int value);
        @(negedge clk);
        start    = 1'b1;
        load_num = digit_t'(value);
        @(negedge clk);
        start    = 1'b0;
        load_num = '0;
    endtask

    task automatic wait_done(input int limit, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (done)
                seen = 1'b1;
        end
    endtask

    initial
    begin
        int ld;
        int err_before;
        int tests_failed;
        bit seen;
        bit timed_out;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        load_num     = '0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(88));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (40) @(negedge clk);    // a frame with nothing loaded
        for (int i = 0; i < num_tests && !timed_out; i++)
        begin
            err_before = errors;
            ld = load_tab[i];
            if (ld < 0)
                ld = int'($urandom_range(MAX_DIGIT, 1));    // restart mid count
            pulse_start(ld);
            if (done_tab[i])
            begin
                wait_done(ld * DIGIT_TICKS + 16, seen);
                if (!seen)
                begin
                    $display("test %0d load %0d: done never came, timed out", i, ld);
                    timed_out = 1'b1;
                    tests_failed++;
                end
            end
            if (!timed_out)
            begin
                repeat (hold_tab[i]) @(negedge clk);
                if (errors == err_before)
                    $display("test %0d load %0d: ok", i, ld);
                else
                begin
                    $display("test %0d load %0d: %0d errors", i, ld, errors - err_before);
                    tests_failed++;
                end
            end
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_tests, tests_failed, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/dz_pkg.sv
hdl/scan_if.sv
hdl/row_scanner.sv
hdl/countdown_seq.sv
hdl/dz_show.sv
hdl/dz_countdown_top.sv
dv/dz_checker.sv
dv/tb_dz_countdown.sv

// File: Makefile
# Verilator flow for the dot-matrix countdown
# override any of these on the command line, e.g. make sim SEED=5 LOG=run.log

TOP       ?= tb_dz_countdown
SEED      ?= 88
LOG       ?= sim.log
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run itself may stop early, the log decides the result
sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
